//--- logic/mp_noc_cfg.svh
// ==========================================================
// Group NoC request path configuration
// Widths, buffer depth and mesh direction indices
// ==========================================================
`ifndef MP_NOC_CFG_SVH
`define MP_NOC_CFG_SVH

`define MP_ADDR_W       32
`define MP_DATA_W       32
`define MP_BE_W         4
`define MP_BYTE_OFS_W   2
`define MP_BANK_W       4
`define MP_TILE_SEL_W   2
`define MP_GROUP_ID_W   4   // Low half X, high half Y
`define MP_ROW_W        8
`define MP_CORE_ID_W    4
`define MP_TGT_ADDR_W   14  // Row, bank, tile
`define MP_BANK_ROW_W   12  // Row, bank
`define MP_FLIT_W       65
`define MP_FIFO_DEPTH   2

// Mesh output directions
`define MP_DIR_NORTH    0
`define MP_DIR_EAST     1
`define MP_DIR_SOUTH    2
`define MP_DIR_WEST     3
`define MP_NUM_DIRS     4

`endif

//--- logic/mp_noc_pkg.sv
// ==========================================================
// Group NoC request path types
// Plain vectors for addresses, ids, payload and the flit
// ==========================================================
`include "mp_noc_cfg.svh"

package mp_noc_pkg;

  // Full byte address from a tile master
  typedef logic [`MP_ADDR_W-1:0]     addr_t;

  // Payload
  typedef logic [`MP_DATA_W-1:0]     data_t;
  typedef logic [`MP_BE_W-1:0]       be_t;

  // Identifiers
  typedef logic [`MP_TILE_SEL_W-1:0] tile_sel_t;
  typedef logic [`MP_GROUP_ID_W-1:0] group_id_t;  // {Y, X}
  typedef logic [`MP_CORE_ID_W-1:0]  core_id_t;

  // Group-local address, tile bits at the bottom
  typedef logic [`MP_TGT_ADDR_W-1:0] tgt_addr_t;

  // Address inside a tile once the tile bits are gone
  typedef logic [`MP_BANK_ROW_W-1:0] bank_row_t;

  // One bit per mesh direction
  typedef logic [`MP_NUM_DIRS-1:0]   dir_vec_t;

  // Request flit, MSB first:
  //   dst group | src group | src tile | core id
  //   tgt addr | wen | be | data
  typedef logic [`MP_FLIT_W-1:0]     flit_t;

endpackage

//--- logic/req_flit_packer.sv
// ==========================================================
// Request flit packer
// Splits the interleaved byte address into a request flit
// ==========================================================
`timescale 1ns/1ps
`include "mp_noc_cfg.svh"

module req_flit_packer (
  // Tile master request
  input  logic                  mst_valid_i,
  output logic                  mst_ready_o,
  input  mp_noc_pkg::addr_t     mst_addr_i,
  input  logic                  mst_wen_i,
  input  mp_noc_pkg::be_t       mst_be_i,
  input  mp_noc_pkg::data_t     mst_data_i,
  input  mp_noc_pkg::core_id_t  mst_core_id_i,
  input  mp_noc_pkg::tile_sel_t mst_src_tile_i,
  // Own group
  input  mp_noc_pkg::group_id_t group_id_i,
  // Flit towards the channel buffer
  output logic                  flit_valid_o,
  input  logic                  flit_ready_i,
  output mp_noc_pkg::flit_t     flit_o
);
  import mp_noc_pkg::*;

  // Field offsets in the byte address
  localparam int unsigned BANK_LSB  = `MP_BYTE_OFS_W;
  localparam int unsigned TILE_LSB  = BANK_LSB + `MP_BANK_W;
  localparam int unsigned GROUP_LSB = TILE_LSB + `MP_TILE_SEL_W;
  localparam int unsigned ROW_LSB   = GROUP_LSB + `MP_GROUP_ID_W;

  group_id_t dst_group;
  tgt_addr_t tgt_addr;

  assign dst_group = mst_addr_i[GROUP_LSB +: `MP_GROUP_ID_W];

  // row | bank | tile, byte offset dropped
  assign tgt_addr = {mst_addr_i[ROW_LSB +: `MP_ROW_W],
                     mst_addr_i[BANK_LSB +: `MP_BANK_W],
                     mst_addr_i[TILE_LSB +: `MP_TILE_SEL_W]};

  assign flit_o = {dst_group,
                   group_id_i,      // Source group for the way back
                   mst_src_tile_i,
                   mst_core_id_i,
                   tgt_addr,
                   mst_wen_i,
                   mst_be_i,
                   mst_data_i};

  // Handshake passes straight through
  assign flit_valid_o = mst_valid_i;
  assign mst_ready_o  = flit_ready_i;

  // A write with no byte lane enabled is a master bug
  always_comb begin
    if (mst_valid_i && mst_wen_i) begin
      assert final (mst_be_i != '0)
        else $error("write request without byte enables, addr %h", mst_addr_i);
    end
  end

endmodule

//--- logic/flit_channel_fifo.sv
// ==========================================================
// Flit channel buffer
// Circular FIFO with valid/ready on both sides
// ==========================================================
`timescale 1ns/1ps
`include "mp_noc_cfg.svh"

module flit_channel_fifo #(
  parameter int unsigned WIDTH = $bits(mp_noc_pkg::flit_t),
  parameter int unsigned DEPTH = `MP_FIFO_DEPTH
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  // Write side
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  logic [WIDTH-1:0] in_data_i,
  // Read side
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic [WIDTH-1:0] out_data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push;
  logic             pop;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready_o  = (cnt_q != CNT_W'(DEPTH));  // No push while full
  assign out_valid_o = (cnt_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];           // Head visible right after write

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= in_data_i;
  end

  // Occupancy stays in range and agrees with the pointers
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (cnt_q <= CNT_W'(DEPTH)) &&
    ((int'(rd_ptr_q) + int'(cnt_q)) % int'(DEPTH) == int'(wr_ptr_q)))
    else $error("FIFO overflow or underflow, count %0d", cnt_q);

  // A stalled head holds
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)))
    else $error("FIFO head changed while stalled");

endmodule

//--- logic/xy_route_stage.sv
// ==========================================================
// XY route stage
// Sends a flit to a mesh output or to the local tile port
// ==========================================================
`timescale 1ns/1ps
`include "mp_noc_cfg.svh"

module xy_route_stage (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  mp_noc_pkg::group_id_t group_id_i,
  // Flit from the channel buffer
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  mp_noc_pkg::flit_t     in_flit_i,
  // Mesh outputs
  output mp_noc_pkg::dir_vec_t  mesh_valid_o,
  input  mp_noc_pkg::dir_vec_t  mesh_ready_i,
  output mp_noc_pkg::flit_t     mesh_flit_o,
  // Local tile port
  output logic                  slv_valid_o,
  input  logic                  slv_ready_i,
  output mp_noc_pkg::tile_sel_t slv_tile_sel_o,
  output mp_noc_pkg::bank_row_t slv_addr_o,
  output logic                  slv_wen_o,
  output mp_noc_pkg::be_t       slv_be_o,
  output mp_noc_pkg::data_t     slv_data_o,
  output mp_noc_pkg::core_id_t  slv_core_id_o,
  output mp_noc_pkg::tile_sel_t slv_src_tile_o,
  output mp_noc_pkg::group_id_t slv_src_group_o
);
  import mp_noc_pkg::*;

  localparam int unsigned COORD_W = `MP_GROUP_ID_W / 2;

  // Unpacked flit fields
  group_id_t dst_group;
  group_id_t src_group;
  tile_sel_t src_tile;
  core_id_t  core_id;
  tgt_addr_t tgt_addr;
  logic      wen;
  be_t       be;
  data_t     data;

  logic [COORD_W-1:0] own_x;
  logic [COORD_W-1:0] own_y;
  logic [COORD_W-1:0] dst_x;
  logic [COORD_W-1:0] dst_y;

  dir_vec_t route_dir;
  logic     route_local;

  assign {dst_group, src_group, src_tile, core_id, tgt_addr, wen, be, data} = in_flit_i;

  assign own_x = group_id_i[COORD_W-1:0];
  assign own_y = group_id_i[`MP_GROUP_ID_W-1:COORD_W];
  assign dst_x = dst_group[COORD_W-1:0];
  assign dst_y = dst_group[`MP_GROUP_ID_W-1:COORD_W];

  // Dimension order routing, X resolved first
  always_comb begin
    route_dir   = '0;
    route_local = 1'b0;
    if (dst_x > own_x) begin
      route_dir[`MP_DIR_EAST] = 1'b1;
    end else if (dst_x < own_x) begin
      route_dir[`MP_DIR_WEST] = 1'b1;
    end else if (dst_y > own_y) begin
      route_dir[`MP_DIR_NORTH] = 1'b1;
    end else if (dst_y < own_y) begin
      route_dir[`MP_DIR_SOUTH] = 1'b1;
    end else begin
      route_local = 1'b1;  // Arrived
    end
  end

  assign mesh_valid_o = in_valid_i ? route_dir : '0;
  assign mesh_flit_o  = in_flit_i;  // Shared by all directions

  assign slv_valid_o     = in_valid_i & route_local;
  assign slv_tile_sel_o  = tgt_addr[`MP_TILE_SEL_W-1:0];
  assign slv_addr_o      = tgt_addr[`MP_TGT_ADDR_W-1:`MP_TILE_SEL_W];  // Tile bits stripped
  assign slv_wen_o       = wen;
  assign slv_be_o        = be;
  assign slv_data_o      = data;
  assign slv_core_id_o   = core_id;
  assign slv_src_tile_o  = src_tile;
  assign slv_src_group_o = src_group;

  // Pop only once the chosen output takes the flit
  assign in_ready_o = route_local ? slv_ready_i : |(route_dir & mesh_ready_i);

  // A stalled flit keeps its output and its contents
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (in_valid_i && !in_ready_o) |=>
      ($stable({mesh_valid_o, slv_valid_o}) && $stable(in_flit_i)))
    else $error("routed output changed while stalled, mesh %b local %b",
                mesh_valid_o, slv_valid_o);

endmodule

//--- logic/group_noc_req_top.sv
// ==========================================================
// Group NoC request path
// Flit packer, channel buffer and XY route stage
// ==========================================================
`timescale 1ns/1ps
`include "mp_noc_cfg.svh"

module group_noc_req_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  mp_noc_pkg::group_id_t group_id_i,
  // Tile master request
  input  logic                  mst_valid_i,
  output logic                  mst_ready_o,
  input  mp_noc_pkg::addr_t     mst_addr_i,
  input  logic                  mst_wen_i,
  input  mp_noc_pkg::be_t       mst_be_i,
  input  mp_noc_pkg::data_t     mst_data_i,
  input  mp_noc_pkg::core_id_t  mst_core_id_i,
  input  mp_noc_pkg::tile_sel_t mst_src_tile_i,
  // Mesh outputs
  output mp_noc_pkg::dir_vec_t  mesh_valid_o,
  input  mp_noc_pkg::dir_vec_t  mesh_ready_i,
  output mp_noc_pkg::flit_t     mesh_flit_o,
  // Local tile port
  output logic                  slv_valid_o,
  input  logic                  slv_ready_i,
  output mp_noc_pkg::tile_sel_t slv_tile_sel_o,
  output mp_noc_pkg::bank_row_t slv_addr_o,
  output logic                  slv_wen_o,
  output mp_noc_pkg::be_t       slv_be_o,
  output mp_noc_pkg::data_t     slv_data_o,
  output mp_noc_pkg::core_id_t  slv_core_id_o,
  output mp_noc_pkg::tile_sel_t slv_src_tile_o,
  output mp_noc_pkg::group_id_t slv_src_group_o
);
  import mp_noc_pkg::*;

  // Packer to buffer
  logic  flit_valid;
  logic  flit_ready;
  flit_t flit;
  // Buffer to route stage
  logic  fifo_valid;
  logic  fifo_ready;
  flit_t fifo_flit;

  req_flit_packer i_req_flit_packer (
    .mst_valid_i    (mst_valid_i   ),
    .mst_ready_o    (mst_ready_o   ),
    .mst_addr_i     (mst_addr_i    ),
    .mst_wen_i      (mst_wen_i     ),
    .mst_be_i       (mst_be_i      ),
    .mst_data_i     (mst_data_i    ),
    .mst_core_id_i  (mst_core_id_i ),
    .mst_src_tile_i (mst_src_tile_i),
    .group_id_i     (group_id_i    ),
    .flit_valid_o   (flit_valid    ),
    .flit_ready_i   (flit_ready    ),
    .flit_o         (flit          )
  );

  flit_channel_fifo #(
    .WIDTH (`MP_FLIT_W    ),
    .DEPTH (`MP_FIFO_DEPTH)
  ) i_flit_channel_fifo (
    .clk_i       (clk_i     ),
    .arst_n_i    (arst_n_i  ),
    .in_valid_i  (flit_valid),
    .in_ready_o  (flit_ready),
    .in_data_i   (flit      ),
    .out_valid_o (fifo_valid),
    .out_ready_i (fifo_ready),
    .out_data_o  (fifo_flit )
  );

  xy_route_stage i_xy_route_stage (
    .clk_i           (clk_i          ),
    .arst_n_i        (arst_n_i       ),
    .group_id_i      (group_id_i     ),
    .in_valid_i      (fifo_valid     ),
    .in_ready_o      (fifo_ready     ),
    .in_flit_i       (fifo_flit      ),
    .mesh_valid_o    (mesh_valid_o   ),
    .mesh_ready_i    (mesh_ready_i   ),
    .mesh_flit_o     (mesh_flit_o    ),
    .slv_valid_o     (slv_valid_o    ),
    .slv_ready_i     (slv_ready_i    ),
    .slv_tile_sel_o  (slv_tile_sel_o ),
    .slv_addr_o      (slv_addr_o     ),
    .slv_wen_o       (slv_wen_o      ),
    .slv_be_o        (slv_be_o       ),
    .slv_data_o      (slv_data_o     ),
    .slv_core_id_o   (slv_core_id_o  ),
    .slv_src_tile_o  (slv_src_tile_o ),
    .slv_src_group_o (slv_src_group_o)
  );

endmodule

//--- verif/tb_group_noc_req.sv
// ==========================================================
// Group NoC request path testbench
// Directed and random requests checked against an XY model
// ==========================================================
`timescale 1ns/1ps
`include "mp_noc_cfg.svh"

module tb_group_noc_req;
  import mp_noc_pkg::*;

  localparam int unsigned TIMEOUT = 500;   // Cycles per wait
  localparam group_id_t   OWN_ID  = 4'h9;  // X=1, Y=2

  // Destinations for the directed pass, local first
  localparam group_id_t DST_LIST [7] = '{4'h9, 4'hA, 4'h8, 4'hD, 4'h1, 4'h3, 4'hC};

  typedef struct packed {
    logic      to_local;
    dir_vec_t  dir;
    flit_t     flit;
    tile_sel_t tile;
    bank_row_t row;
  } exp_t;

  logic      clk_i = 1'b0;
  logic      arst_n_i;
  group_id_t group_id_i;
  logic      mst_valid_i;
  logic      mst_ready_o;
  addr_t     mst_addr_i;
  logic      mst_wen_i;
  be_t       mst_be_i;
  data_t     mst_data_i;
  core_id_t  mst_core_id_i;
  tile_sel_t mst_src_tile_i;
  dir_vec_t  mesh_valid_o;
  dir_vec_t  mesh_ready_i;
  flit_t     mesh_flit_o;
  logic      slv_valid_o;
  logic      slv_ready_i;
  tile_sel_t slv_tile_sel_o;
  bank_row_t slv_addr_o;
  logic      slv_wen_o;
  be_t       slv_be_o;
  data_t     slv_data_o;
  core_id_t  slv_core_id_o;
  tile_sel_t slv_src_tile_o;
  group_id_t slv_src_group_o;

  exp_t        exp_q[$];
  exp_t        head;
  logic [31:0] lfsr_q = 32'h6ee56b59;
  int unsigned cyc = 0;
  int unsigned last_acc_cyc;
  int unsigned last_out_cyc;
  int unsigned n_sent = 0;
  int unsigned n_out = 0;
  logic        rand_rdy = 1'b0;
  logic [4:0]  nxt_rdy;
  logic        stalled = 1'b0;
  logic [81:0] held;  // Output snapshot while stalled

  group_noc_req_top i_group_noc_req_top (.*);

  always #10 clk_i = ~clk_i;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Expected output of one request from the address map and the XY rule
  function automatic exp_t ref_model(input addr_t addr, input logic wen, input be_t be,
                                     input data_t data, input core_id_t core,
                                     input tile_sel_t src_tile);
    exp_t      e;
    group_id_t dst;
    int        dx;
    int        dy;
    dst        = addr[11:8];
    e.tile     = addr[7:6];
    e.row      = {addr[19:12], addr[5:2]};
    e.flit     = {dst, OWN_ID, src_tile, core, e.row, e.tile, wen, be, data};
    e.dir      = '0;
    e.to_local = 1'b0;
    dx = int'(dst[1:0]) - int'(OWN_ID[1:0]);
    dy = int'(dst[3:2]) - int'(OWN_ID[3:2]);
    if (dx > 0) begin
      e.dir[`MP_DIR_EAST] = 1'b1;
    end else if (dx < 0) begin
      e.dir[`MP_DIR_WEST] = 1'b1;
    end else if (dy > 0) begin
      e.dir[`MP_DIR_NORTH] = 1'b1;
    end else if (dy < 0) begin
      e.dir[`MP_DIR_SOUTH] = 1'b1;
    end else begin
      e.to_local = 1'b1;  // Own group
    end
    return e;
  endfunction

  task automatic fail_value(input string sig, input logic [95:0] got, input logic [95:0] exp);
    $display("FAIL %s got %0h expected %0h", sig, got, exp);
    $display("*** FAILED ***");
    $fatal(1, "value mismatch");
  endtask

  task automatic fail_msg(input string msg);
    $display("ERROR %s", msg);
    $display("*** FAILED ***");
    $fatal(1, "testbench stopped");
  endtask

  // Hold one request until the DUT takes it
  task automatic send_req(input addr_t addr, input logic wen, input be_t be, input data_t data,
                          input core_id_t core, input tile_sel_t src_tile);
    int unsigned waited;
    waited         = 0;
    mst_valid_i    = 1'b1;
    mst_addr_i     = addr;
    mst_wen_i      = wen;
    mst_be_i       = be;
    mst_data_i     = data;
    mst_core_id_i  = core;
    mst_src_tile_i = src_tile;
    do begin
      @(posedge clk_i);
      waited++;
      assert (waited < TIMEOUT) else fail_msg("request not accepted in time");
    end while (!mst_ready_o);
    exp_q.push_back(ref_model(addr, wen, be, data, core, src_tile));
    last_acc_cyc = cyc;
    n_sent++;
    #2;
    mst_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int unsigned waited;
    waited = 0;
    while (n_out != n_sent) begin
      @(posedge clk_i);
      #2;
      waited++;
      assert (waited < TIMEOUT) else fail_msg("outputs did not deliver all requests in time");
    end
  endtask

  // Random backpressure, drawn at the edge and driven just after it
  always @(posedge clk_i) begin
    if (rand_rdy) begin
      nxt_rdy = 5'(rand_bits(5));
      #2;
      {mesh_ready_i, slv_ready_i} = nxt_rdy;
    end
  end

  // Scoreboard
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (arst_n_i) begin
      if (stalled) begin
        assert (held == {mesh_valid_o, slv_valid_o, mesh_flit_o, slv_addr_o})
          else fail_value("held output", 96'(held),
                          96'({mesh_valid_o, slv_valid_o, mesh_flit_o, slv_addr_o}));
      end
      if (|(mesh_valid_o & mesh_ready_i) || (slv_valid_o && slv_ready_i)) begin
        assert (exp_q.size() > 0) else fail_msg("output transfer with nothing outstanding");
        head         = exp_q.pop_front();
        last_out_cyc = cyc;
        n_out++;
        assert ({mesh_valid_o, slv_valid_o} == {head.dir, head.to_local})
          else fail_value("mesh_valid_o/slv_valid_o", 96'({mesh_valid_o, slv_valid_o}),
                          96'({head.dir, head.to_local}));
        if (head.to_local) begin
          assert (slv_tile_sel_o == head.tile)
            else fail_value("slv_tile_sel_o", 96'(slv_tile_sel_o), 96'(head.tile));
          assert (slv_addr_o == head.row)
            else fail_value("slv_addr_o", 96'(slv_addr_o), 96'(head.row));
          assert ({slv_src_group_o, slv_src_tile_o, slv_core_id_o} == head.flit[60:51])
            else fail_value("slv_src_group_o/slv_src_tile_o/slv_core_id_o",
                            96'({slv_src_group_o, slv_src_tile_o, slv_core_id_o}),
                            96'(head.flit[60:51]));
          assert ({slv_wen_o, slv_be_o, slv_data_o} == head.flit[36:0])
            else fail_value("slv_wen_o/slv_be_o/slv_data_o",
                            96'({slv_wen_o, slv_be_o, slv_data_o}), 96'(head.flit[36:0]));
        end else begin
          assert (mesh_flit_o == head.flit)
            else fail_value("mesh_flit_o", 96'(mesh_flit_o), 96'(head.flit));
        end
      end
      stalled = (|mesh_valid_o && !(|(mesh_valid_o & mesh_ready_i))) ||
                (slv_valid_o && !slv_ready_i);
      held    = {mesh_valid_o, slv_valid_o, mesh_flit_o, slv_addr_o};
    end
  end

  initial begin
    addr_t       addr;
    logic        wen;
    be_t         be;
    data_t       data;
    core_id_t    core;
    tile_sel_t   tile;
    int unsigned gap;
    arst_n_i       = 1'b0;
    group_id_i     = OWN_ID;
    mst_valid_i    = 1'b0;
    mst_addr_i     = '0;
    mst_wen_i      = 1'b0;
    mst_be_i       = '0;
    mst_data_i     = '0;
    mst_core_id_i  = '0;
    mst_src_tile_i = '0;
    mesh_ready_i   = '1;
    slv_ready_i    = 1'b1;
    repeat (2) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;
    @(posedge clk_i);
    #2;
    assert ({mesh_valid_o, slv_valid_o, mst_ready_o} == 6'b000001)
      else fail_value("mesh_valid_o/slv_valid_o/mst_ready_o",
                      96'({mesh_valid_o, slv_valid_o, mst_ready_o}), 96'(6'b000001));

    // Local port and every XY direction, empty buffer
    for (int i = 0; i < 7; i++) begin
      send_req({12'h0, 8'(i * 37), DST_LIST[i], 2'(i), 4'(i + 3), 2'b0}, 1'(i), 4'hf,
               32'hc0de0000 ^ 32'(i), 4'(i), 2'(i + 1));
      wait_drain();
      assert (last_out_cyc == last_acc_cyc + 1)
        else fail_msg("output not visible one cycle after acceptance");
    end

    // All outputs blocked, two requests fill the buffer
    mesh_ready_i = '0;
    slv_ready_i  = 1'b0;
    send_req({12'h0, 8'h11, 4'hA, 2'd1, 4'h2, 2'd0}, 1'b1, 4'h3, 32'h0000aaaa, 4'h1, 2'd0);
    send_req({12'h0, 8'h22, OWN_ID, 2'd2, 4'h5, 2'd0}, 1'b0, 4'h0, 32'h0000bbbb, 4'h2, 2'd3);
    mst_valid_i    = 1'b1;
    mst_addr_i     = {12'h0, 8'h33, 4'h1, 2'd0, 4'h9, 2'd0};
    mst_data_i     = 32'h0000cccc;
    mst_core_id_i  = 4'h3;
    mst_src_tile_i = 2'd2;
    repeat (8) begin
      @(posedge clk_i);
      assert (!mst_ready_o) else fail_msg("request accepted while the buffer was full");
    end
    #2;
    mesh_ready_i = '1;
    slv_ready_i  = 1'b1;
    send_req({12'h0, 8'h33, 4'h1, 2'd0, 4'h9, 2'd0}, 1'b0, 4'h0, 32'h0000cccc, 4'h3, 2'd2);
    wait_drain();

    // Random stream under random backpressure
    rand_rdy = 1'b1;
    repeat (400) begin
      addr = rand_bits(32);
      wen  = 1'(rand_bits(1));
      be   = 4'(rand_bits(4));
      if (wen && be == '0) be = 4'h1;
      data = rand_bits(32);
      core = 4'(rand_bits(4));
      tile = 2'(rand_bits(2));
      send_req(addr, wen, be, data, core, tile);
      gap = rand_bits(2);
      repeat (gap) begin
        @(posedge clk_i);
        #2;
      end
    end
    wait_drain();

    if (exp_q.size() == 0 && n_out == n_sent) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      fail_msg("expected outputs left over at the end");
    end
  end

endmodule

//--- tb.f
+incdir+logic
logic/mp_noc_pkg.sv
logic/req_flit_packer.sv
logic/flit_channel_fifo.sv
logic/xy_route_stage.sv
logic/group_noc_req_top.sv
verif/tb_group_noc_req.sv

//--- Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vtb_group_noc_req: tb.f logic/*.sv logic/*.svh verif/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f tb.f --top-module tb_group_noc_req

run: obj_dir/Vtb_group_noc_req
	@out=$$(./obj_dir/Vtb_group_noc_req); echo "$$out"; \
		echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
		-f tb.f --top-module tb_group_noc_req

clean:
	rm -rf obj_dir
